//--- Makefile
# Verilator flow for the PS/2 keyboard front end

VERILATOR ?= verilator
FLIST     ?= ps2Kbd.f
TOP       ?= tbPs2Kbd
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) include/ps2Kbd_defs.svh

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps -f $(FLIST) --top-module $(TOP)

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)

sim: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

//--- bench/tbPs2Kbd.sv
`timescale 1ns/1ps
`include "ps2Kbd_defs.svh"

module tbPs2Kbd;

	localparam int strobeLimit = 16;
	localparam int resetLimit = 50;

	// set 2 codes, a to z then 0 to 9
	localparam logic [7:0] keyCodes [36] = '{
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
		8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
		8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
		8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
	};

	logic clk;
	logic rstN;
	logic ps2Clk;
	logic ps2Data;
	logic [7:0] keyCount;
	logic [7:0] curKey;
	logic [7:0] asciiKey;
	logic flagShift;
	logic flagCtrl;
	logic flagCaps;
	logic keyDown;

	// reference model state
	logic [7:0] expCount;
	logic [7:0] expKey;
	logic [7:0] expAscii;
	logic expShift;
	logic expCtrl;
	logic expCaps;
	logic expDown;
	logic breakPend;

	logic checkNow;
	logic badWindow; // no strobe allowed while high
	logic [31:0] rngState;
	int strobeCount;
	int valueErrors;
	int otherErrors;
	string testName;

	tbClock u_clock (
		.clk(clk),
		.rstN(rstN)
	);

	ps2Kbd u_dut (
		.clk(clk),
		.rstN(rstN),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.keyCount(keyCount),
		.curKey(curKey),
		.asciiKey(asciiKey),
		.flagShift(flagShift),
		.flagCtrl(flagCtrl),
		.flagCaps(flagCaps),
		.keyDown(keyDown)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] pickCode(input int first, input int span);
		int idx;
		rngState = xorshift(rngState);
		idx = first + int'(rngState % 32'(span));
		return keyCodes[idx];
	endfunction

	function automatic logic [7:0] asciiOf(input logic [7:0] code, input logic upper);
		for (int i = 0; i < 36; i++) begin
			if (code == keyCodes[i]) begin
				if (i >= 26) begin
					return 8'h30 + 8'(i - 26);
				end
				return (upper ? 8'h41 : 8'h61) + 8'(i);
			end
		end
		case (code)
			8'h29: return 8'h20;
			8'h5A: return 8'h0D;
			8'h66: return 8'h08;
			default: return 8'h00;
		endcase
	endfunction

	assign expAscii = asciiOf(expKey, expShift | expCaps);

	always @(posedge clk) begin
		if (u_dut.codeValid) begin
			strobeCount <= strobeCount + 1;
		end
	end

	task automatic reportValue(input string what, input logic [7:0] expected,
			input logic [7:0] actual);
		valueErrors++;
		$display("CHECK FAILED %s %s: expected %0h, actual %0h", testName, what, expected, actual);
	endtask

	assert property (@(posedge clk) disable iff (!rstN) checkNow |-> keyCount == expCount)
		else reportValue("keyCount", expCount, keyCount);
	assert property (@(posedge clk) disable iff (!rstN) checkNow |-> curKey == expKey)
		else reportValue("curKey", expKey, curKey);
	assert property (@(posedge clk) disable iff (!rstN) checkNow |-> asciiKey == expAscii)
		else reportValue("asciiKey", expAscii, asciiKey);
	assert property (@(posedge clk) disable iff (!rstN) checkNow |-> flagShift == expShift)
		else reportValue("flagShift", {7'b0, expShift}, {7'b0, flagShift});
	assert property (@(posedge clk) disable iff (!rstN) checkNow |-> flagCtrl == expCtrl)
		else reportValue("flagCtrl", {7'b0, expCtrl}, {7'b0, flagCtrl});
	assert property (@(posedge clk) disable iff (!rstN) checkNow |-> flagCaps == expCaps)
		else reportValue("flagCaps", {7'b0, expCaps}, {7'b0, flagCaps});
	assert property (@(posedge clk) disable iff (!rstN) checkNow |-> keyDown == expDown)
		else reportValue("keyDown", {7'b0, expDown}, {7'b0, keyDown});
	assert property (@(posedge clk) disable iff (!rstN) badWindow |-> !u_dut.codeValid)
		else begin
			otherErrors++;
			$display("%s: a frame with bad parity was accepted", testName);
		end

	// tracker rules applied to every good code
	task automatic applyModel(input logic [7:0] code);
		if (code == `SC_BREAK) begin
			breakPend = 1'b1;
		end else if (breakPend) begin
			breakPend = 1'b0;
			expKey = 8'h00;
			if (code == `SC_LSHIFT) begin
				expShift = 1'b0;
			end else if (code == `SC_LCTRL) begin
				expCtrl = 1'b0;
			end else begin
				expDown = 1'b0;
			end
		end else if (code != expKey) begin
			expCount = expCount + 8'd1;
			expKey = code;
			if (code == `SC_LSHIFT) begin
				expShift = 1'b1;
			end else if (code == `SC_LCTRL) begin
				expCtrl = 1'b1;
			end else if (code == `SC_CAPS) begin
				expCaps = ~expCaps;
			end else begin
				expDown = 1'b1;
			end
		end
	endtask

	task automatic pulseCheck();
		checkNow <= 1'b1;
		@(posedge clk);
		checkNow <= 1'b0;
		badWindow <= 1'b0;
	endtask

	// keyboard clock period of 8 clk cycles, data changes while high
	task automatic sendFrame(input logic [7:0] code, input logic badParity);
		logic [`PS2_FRAME_BITS-1:0] bits;
		int target;
		int waited;
		bits = {1'b1, (~^code) ^ badParity, code, 1'b0};
		target = badParity ? strobeCount : strobeCount + 1;
		badWindow <= badParity;
		for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
			ps2Data <= bits[i];
			repeat (4) @(posedge clk);
			ps2Clk <= 1'b0;
			repeat (4) @(posedge clk);
			ps2Clk <= 1'b1;
		end
		waited = 0;
		while (strobeCount != target && waited < strobeLimit) begin
			@(posedge clk);
			waited++;
		end
		if (strobeCount != target) begin
			otherErrors++;
			$display("%s: timeout, no strobe for code %h after %0d cycles", testName, code, waited);
		end else if (!badParity) begin
			applyModel(code);
		end
		pulseCheck();
	endtask

	task automatic pressKey(input logic [7:0] code);
		sendFrame(code, 1'b0);
	endtask

	task automatic releaseKey(input logic [7:0] code);
		sendFrame(`SC_BREAK, 1'b0);
		sendFrame(code, 1'b0);
	endtask

	task automatic tapKey(input logic [7:0] code);
		pressKey(code);
		releaseKey(code);
	endtask

	initial begin
		logic [7:0] k;
		int waited;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		checkNow = 1'b0;
		badWindow = 1'b0;
		expCount = 8'h00;
		expKey = 8'h00;
		expShift = 1'b0;
		expCtrl = 1'b0;
		expCaps = 1'b0;
		expDown = 1'b0;
		breakPend = 1'b0;
		strobeCount = 0;
		valueErrors = 0;
		otherErrors = 0;
		rngState = 32'hbd6c_978a;

		testName = "reset";
		waited = 0;
		while (rstN !== 1'b1 && waited < resetLimit) begin
			@(posedge clk);
			waited++;
		end
		if (rstN !== 1'b1) begin
			otherErrors++;
			$display("reset was never released");
		end
		@(posedge clk);
		pulseCheck();

		testName = "makeBreak";
		k = pickCode(0, 36);
		pressKey(k);
		pressKey(k); // typematic repeat
		releaseKey(k);
		tapKey(8'h5A);
		tapKey(8'h29);
		tapKey(8'h66);

		testName = "shift";
		k = pickCode(0, 26);
		pressKey(`SC_LSHIFT);
		tapKey(k);
		releaseKey(`SC_LSHIFT);
		tapKey(k);
		testName = "ctrl";
		pressKey(`SC_LCTRL);
		releaseKey(`SC_LCTRL);

		testName = "caps";
		tapKey(`SC_CAPS);
		tapKey(pickCode(0, 26));
		tapKey(pickCode(26, 10));
		tapKey(`SC_CAPS);
		tapKey(pickCode(0, 26));

		testName = "badParity";
		k = pickCode(0, 36);
		sendFrame(k, 1'b1);
		pressKey(k);
		releaseKey(k);

		testName = "random";
		for (int n = 0; n < 40; n++) begin
			k = pickCode(0, 36);
			pressKey(k);
			rngState = xorshift(rngState);
			if (rngState[0]) begin
				pressKey(k);
			end
			releaseKey(k);
		end

		repeat (4) @(posedge clk);
		$display("errors: %0d value, %0d other", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- include/ps2Kbd_defs.svh
`ifndef PS2KBD_DEFS_SVH
`define PS2KBD_DEFS_SVH

// start, eight data bits, parity, stop
`define PS2_FRAME_BITS 11

// flops on the keyboard clock before edge detection
`define PS2_SYNC_DEPTH 3

// set 2 scan codes with special meaning
`define SC_BREAK  8'hF0
`define SC_LSHIFT 8'h12
`define SC_LCTRL  8'h14
`define SC_CAPS   8'h58

`endif

//--- logic/asciiMap.sv
`timescale 1ns/1ps

module asciiMap import ps2KbdPkg::*; (
	input logic clk,
	input logic rstN,
	input logic upper,
	input scanCodeT curKey,
	output asciiT asciiKey
);

	asciiT lowerCh;
	asciiT nextCh;

	// set 2 codes, lower case form
	always_comb begin
		case (curKey)
			8'h1C: lowerCh = "a";
			8'h32: lowerCh = "b";
			8'h21: lowerCh = "c";
			8'h23: lowerCh = "d";
			8'h24: lowerCh = "e";
			8'h2B: lowerCh = "f";
			8'h34: lowerCh = "g";
			8'h33: lowerCh = "h";
			8'h43: lowerCh = "i";
			8'h3B: lowerCh = "j";
			8'h42: lowerCh = "k";
			8'h4B: lowerCh = "l";
			8'h3A: lowerCh = "m";
			8'h31: lowerCh = "n";
			8'h44: lowerCh = "o";
			8'h4D: lowerCh = "p";
			8'h15: lowerCh = "q";
			8'h2D: lowerCh = "r";
			8'h1B: lowerCh = "s";
			8'h2C: lowerCh = "t";
			8'h3C: lowerCh = "u";
			8'h2A: lowerCh = "v";
			8'h1D: lowerCh = "w";
			8'h22: lowerCh = "x";
			8'h35: lowerCh = "y";
			8'h1A: lowerCh = "z";
			8'h45: lowerCh = "0";
			8'h16: lowerCh = "1";
			8'h1E: lowerCh = "2";
			8'h26: lowerCh = "3";
			8'h25: lowerCh = "4";
			8'h2E: lowerCh = "5";
			8'h36: lowerCh = "6";
			8'h3D: lowerCh = "7";
			8'h3E: lowerCh = "8";
			8'h46: lowerCh = "9";
			8'h29: lowerCh = 8'h20; // space
			8'h5A: lowerCh = 8'h0D; // enter
			8'h66: lowerCh = 8'h08; // backspace
			default: lowerCh = 8'h00;
		endcase
	end

	// only letters have a case, digits pass as they are
	assign nextCh = (upper && lowerCh >= "a" && lowerCh <= "z") ? lowerCh - 8'h20 : lowerCh;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			asciiKey <= '0;
		end else begin
			asciiKey <= nextCh;
		end
	end

endmodule

//--- logic/keyTracker.sv
`timescale 1ns/1ps
`include "ps2Kbd_defs.svh"

module keyTracker import ps2KbdPkg::*; (
	input logic clk,
	input logic rstN,
	input scanCodeT scanCode,
	input logic codeValid,
	output keyCountT keyCount,
	output scanCodeT curKey,
	output logic flagShift,
	output logic flagCtrl,
	output logic flagCaps,
	output logic keyDown
);

	typedef enum logic {
		StMake,
		StBreak // F0 seen, next code is a release
	} trkStateT;

	trkStateT state;
	logic isBreak;
	logic isShift;
	logic isCtrl;
	logic isCaps;
	logic newMake;

	assign isBreak = (scanCode == `SC_BREAK);
	assign isShift = (scanCode == `SC_LSHIFT);
	assign isCtrl = (scanCode == `SC_LCTRL);
	assign isCaps = (scanCode == `SC_CAPS);

	// curKey holds the last make code, zero once released
	assign newMake = (scanCode != curKey);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= StMake;
			keyCount <= '0;
			curKey <= '0;
			flagShift <= 1'b0;
			flagCtrl <= 1'b0;
			flagCaps <= 1'b0;
			keyDown <= 1'b0;
		end else if (codeValid) begin
			if (isBreak) begin
				state <= StBreak;
			end else begin
				case (state)
					StBreak: begin
						state <= StMake;
						curKey <= '0;
						if (isShift) begin
							flagShift <= 1'b0;
						end else if (isCtrl) begin
							flagCtrl <= 1'b0;
						end else begin
							keyDown <= 1'b0;
						end
					end
					default: begin
						// typematic repeats carry the same code
						if (newMake) begin
							keyCount <= keyCount + keyCountT'(1);
							curKey <= scanCode;
							if (isShift) begin
								flagShift <= 1'b1;
							end else if (isCtrl) begin
								flagCtrl <= 1'b1;
							end else if (isCaps) begin
								flagCaps <= ~flagCaps; // toggles per press
							end else begin
								keyDown <= 1'b1;
							end
						end
					end
				endcase
			end
		end
	end

	// counter only moves on a received code
	assert property (@(posedge clk) disable iff (!rstN)
		$changed(keyCount) |-> $past(codeValid));

endmodule

//--- logic/ps2Kbd.sv
`timescale 1ns/1ps

module ps2Kbd import ps2KbdPkg::*; (
	input logic clk,
	input logic rstN,
	input logic ps2Clk, // async to clk
	input logic ps2Data,
	output keyCountT keyCount,
	output scanCodeT curKey,
	output asciiT asciiKey,
	output logic flagShift,
	output logic flagCtrl,
	output logic flagCaps,
	output logic keyDown
);

	scanCodeT scanCode;
	logic codeValid;

	ps2Rx u_ps2Rx (
		.clk(clk),
		.rstN(rstN),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.scanCode(scanCode),
		.codeValid(codeValid)
	);

	keyTracker u_keyTracker (
		.clk(clk),
		.rstN(rstN),
		.scanCode(scanCode),
		.codeValid(codeValid),
		.keyCount(keyCount),
		.curKey(curKey),
		.flagShift(flagShift),
		.flagCtrl(flagCtrl),
		.flagCaps(flagCaps),
		.keyDown(keyDown)
	);

	// either shift or caps lock selects upper case
	asciiMap u_asciiMap (
		.clk(clk),
		.rstN(rstN),
		.upper(flagShift | flagCaps),
		.curKey(curKey),
		.asciiKey(asciiKey)
	);

endmodule

//--- logic/ps2KbdPkg.sv
package ps2KbdPkg;

	// raw byte from the keyboard
	typedef logic [7:0] scanCodeT;

	typedef logic [7:0] asciiT;

	// wraps at 256
	typedef logic [7:0] keyCountT;

endpackage

//--- logic/ps2Rx.sv
`timescale 1ns/1ps
`include "ps2Kbd_defs.svh"

module ps2Rx import ps2KbdPkg::*; (
	input logic clk,
	input logic rstN,
	input logic ps2Clk,
	input logic ps2Data,
	output scanCodeT scanCode,
	output logic codeValid
);

	localparam int BitCntW = $clog2(`PS2_FRAME_BITS);

	logic [`PS2_SYNC_DEPTH-1:0] clkSync;
	logic [`PS2_SYNC_DEPTH-2:0] dataSync; // one stage short, lines up with clkSync
	logic [BitCntW-1:0] bitCnt;
	logic [`PS2_FRAME_BITS-2:0] frameBuf; // start, data, parity
	logic fallEdge;
	logic dataBit;
	logic lastBit;
	logic badStart;
	logic frameOk;

	// both lines idle high
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			clkSync <= '1;
			dataSync <= '1;
		end else begin
			clkSync <= {clkSync[`PS2_SYNC_DEPTH-2:0], ps2Clk};
			dataSync <= {dataSync[`PS2_SYNC_DEPTH-3:0], ps2Data};
		end
	end

	assign fallEdge = clkSync[`PS2_SYNC_DEPTH-1] & ~clkSync[`PS2_SYNC_DEPTH-2];
	assign dataBit = dataSync[`PS2_SYNC_DEPTH-2];
	assign lastBit = (bitCnt == BitCntW'(`PS2_FRAME_BITS - 1));
	assign badStart = (bitCnt == '0) && dataBit; // start bit must be low

	// start low, stop high, odd parity over data plus parity bit
	assign frameOk = !frameBuf[0] && dataBit && (^frameBuf[`PS2_FRAME_BITS-2:1]);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bitCnt <= '0;
			codeValid <= 1'b0;
		end else begin
			codeValid <= 1'b0;
			if (fallEdge) begin
				if (lastBit) begin
					bitCnt <= '0; // good or bad, start over
					codeValid <= frameOk;
				end else if (!badStart) begin
					bitCnt <= bitCnt + 1'b1;
				end
			end
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk) begin
		if (fallEdge && !lastBit) begin
			frameBuf <= {dataBit, frameBuf[`PS2_FRAME_BITS-2:1]};
		end
		if (fallEdge && lastBit && frameOk) begin
			scanCode <= frameBuf[8:1];
		end
	end

	// strobe is a single pulse per frame
	assert property (@(posedge clk) disable iff (!rstN)
		codeValid |=> !codeValid);

	assert property (@(posedge clk) disable iff (!rstN)
		codeValid |-> !$isunknown(scanCode));

endmodule

//--- ps2Kbd.f
+incdir+include
logic/ps2KbdPkg.sv
logic/ps2Rx.sv
logic/keyTracker.sv
logic/asciiMap.sv
logic/ps2Kbd.sv
bench/tbClock.sv
bench/tbPs2Kbd.sv
